// ==== iqcor_consts.svh ====
/*
 * iq imbalance corrector constants
 * widths, fraction bits, queue depth and multiplier latency
 */

`ifndef IQCOR_CONSTS_SVH
`define IQCOR_CONSTS_SVH

// sample width on the converter side
`define IQCOR_DW      16
// coefficient width, signed q2.14
`define IQCOR_CW      16
// coefficient fraction bits, also the result shift
`define IQCOR_FRAC    14
// tag carried alongside each sample pair
`define IQCOR_TW      8
// output queue entries, power of two
`define IQCOR_QDEPTH  8
// register stages inside iqcor_mul
`define IQCOR_MUL_LAT 3

`endif

// ==== iqcor_pkg.sv ====
/*
 * iq imbalance corrector types
 * vector typedefs and packed structs shared by rtl and testbench
 */

package iqcor_pkg;

  `include "iqcor_consts.svh"

  // plain vectors with a meaning
  typedef logic signed [`IQCOR_DW-1:0]           sample_t;
  typedef logic signed [`IQCOR_CW-1:0]           coef_t;
  // 17x17 signed product
  typedef logic signed [`IQCOR_DW+`IQCOR_CW+1:0] prod_t;
  typedef logic [`IQCOR_TW-1:0]                  tag_t;

  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_pair_t;

  // what enters and leaves the corrector
  typedef struct packed {
    iq_pair_t data;
    tag_t     tag;
  } iq_beat_t;

  typedef struct packed {
    coef_t c_ii;
    coef_t c_iq;
    coef_t c_qi;
    coef_t c_qq;
  } coef_set_t;

  // sideband riding through the multipliers
  typedef struct packed {
    logic vld;
    tag_t tag;
  } side_t;

endpackage

// ==== iqcor_mul.sv ====
/*
 * signed 17x17 multiplier, three register stages
 * sideband delay line matched to the product pipeline
 */

`timescale 1ns/100ps

`include "iqcor_consts.svh"

module iqcor_mul (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic signed [`IQCOR_DW:0] data_a,
  input  logic signed [`IQCOR_DW:0] data_b,
  output iqcor_pkg::prod_t         data_p,
  input  iqcor_pkg::side_t         side_in,
  output iqcor_pkg::side_t         side_out
);

  // operand, product and output registers
  logic signed [`IQCOR_DW:0] a_r;
  logic signed [`IQCOR_DW:0] b_r;
  iqcor_pkg::prod_t          m_r;
  iqcor_pkg::prod_t          p_r;

  // sideband stages, one per data stage
  iqcor_pkg::side_t          side_pipe [`IQCOR_MUL_LAT];

  // **************************************************
  // data path, no reset
  // **************************************************
  always_ff @(posedge clk) begin
    a_r <= data_a;
    b_r <= data_b;
    m_r <= a_r * b_r;
    p_r <= m_r;
  end

  assign data_p = p_r;

  // **************************************************
  // sideband delay line
  // **************************************************
  always_ff @(posedge clk) begin
    // tags just follow along
    side_pipe[0].tag <= side_in.tag;
    for (int s = 1; s < `IQCOR_MUL_LAT; s++) begin
      side_pipe[s].tag <= side_pipe[s-1].tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < `IQCOR_MUL_LAT; s++) begin
        side_pipe[s].vld <= 1'b0;
      end
    end else begin
      side_pipe[0].vld <= side_in.vld;
      for (int s = 1; s < `IQCOR_MUL_LAT; s++) begin
        side_pipe[s].vld <= side_pipe[s-1].vld;
      end
    end
  end

  assign side_out = side_pipe[`IQCOR_MUL_LAT-1];

endmodule

// ==== iqcor_lane.sv ====
/*
 * one corrected output component
 * y = sat16((x_i*c_a + x_q*c_b) >>> frac), one register after the multipliers
 */

`timescale 1ns/100ps

`include "iqcor_consts.svh"

module iqcor_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  iqcor_pkg::sample_t x_i,
  input  iqcor_pkg::sample_t x_q,
  input  iqcor_pkg::coef_t   c_a,
  input  iqcor_pkg::coef_t   c_b,
  input  iqcor_pkg::side_t   side_in,
  output iqcor_pkg::sample_t y,
  output iqcor_pkg::side_t   side_out
);

  // sum of two 34-bit products needs one extra bit
  localparam int SUM_W = `IQCOR_DW + `IQCOR_CW + 3;

  localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(32767);
  localparam logic signed [SUM_W-1:0] SAT_MIN = -SUM_W'(32768);

  // sign-extended multiplier operands
  logic signed [`IQCOR_DW:0] op_xi;
  logic signed [`IQCOR_DW:0] op_xq;
  logic signed [`IQCOR_DW:0] op_ca;
  logic signed [`IQCOR_DW:0] op_cb;

  iqcor_pkg::prod_t    prod_a;
  iqcor_pkg::prod_t    prod_b;
  iqcor_pkg::side_t    side_a;
  iqcor_pkg::side_t    side_b;

  logic signed [SUM_W-1:0] sum;
  logic signed [SUM_W-1:0] sum_sh;
  iqcor_pkg::sample_t      y_next;

  iqcor_pkg::sample_t      y_r;
  iqcor_pkg::side_t        side_r;

  assign op_xi = {x_i[`IQCOR_DW-1], x_i};
  assign op_xq = {x_q[`IQCOR_DW-1], x_q};
  assign op_ca = {c_a[`IQCOR_CW-1], c_a};
  assign op_cb = {c_b[`IQCOR_CW-1], c_b};

  // x_i * c_a
  iqcor_mul mul_a (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_a   (op_xi),
    .data_b   (op_ca),
    .data_p   (prod_a),
    .side_in  (side_in),
    .side_out (side_a)
  );

  // x_q * c_b
  iqcor_mul mul_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_a   (op_xq),
    .data_b   (op_cb),
    .data_p   (prod_b),
    .side_in  (side_in),
    .side_out (side_b)
  );

  // **************************************************
  // sum, shift and clamp
  // **************************************************
  always_comb begin
    sum    = prod_a + prod_b;
    // arithmetic shift, rounds toward minus infinity
    sum_sh = sum >>> `IQCOR_FRAC;
    if (sum_sh > SAT_MAX) begin
      y_next = 16'sh7fff;
    end else if (sum_sh < SAT_MIN) begin
      y_next = 16'sh8000;
    end else begin
      y_next = sum_sh[`IQCOR_DW-1:0];
    end
  end

  // result and tag carry no reset
  always_ff @(posedge clk) begin
    y_r        <= y_next;
    side_r.tag <= side_a.tag;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      side_r.vld <= 1'b0;
    end else begin
      side_r.vld <= side_a.vld;
    end
  end

  assign y        = y_r;
  assign side_out = side_r;

  // both multipliers see the same sideband, so they must stay in step
  a_side_match: assert property (@(posedge clk) disable iff (!rst_n)
    side_a.vld == side_b.vld && (!side_a.vld || side_a.tag == side_b.tag));

endmodule

// ==== iqcor_outq.sv ====
/*
 * output queue with credit-based input ready
 * counts in-flight samples so every accepted beat finds a slot
 */

`timescale 1ns/100ps

`include "iqcor_consts.svh"

module iqcor_outq (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  output logic                accept,
  input  iqcor_pkg::side_t    wr_side_i,
  input  iqcor_pkg::side_t    wr_side_q,
  input  iqcor_pkg::iq_pair_t wr_data,
  output logic                out_valid,
  input  logic                out_ready,
  output iqcor_pkg::iq_beat_t out_beat
);

  localparam int PTR_W = $clog2(`IQCOR_QDEPTH);
  localparam int CNT_W = PTR_W + 1;

  iqcor_pkg::iq_beat_t mem [`IQCOR_QDEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] mem_cnt;
  // accepted but not yet written
  logic [CNT_W-1:0] inflight;
  logic [CNT_W:0]   used;

  // registered head entry
  logic                head_vld;
  iqcor_pkg::iq_beat_t head_beat;

  logic wr_en;
  logic rd_en;
  logic pop;

  assign wr_en = wr_side_i.vld;
  assign pop   = head_vld & out_ready;
  // refill head when it is empty or leaving
  assign rd_en = (mem_cnt != '0) & (!head_vld | out_ready);

  // **************************************************
  // credit accounting
  // **************************************************
  assign used     = {1'b0, mem_cnt} + (CNT_W+1)'(head_vld) + {1'b0, inflight};
  assign in_ready = used < (CNT_W+1)'(`IQCOR_QDEPTH);
  assign accept   = in_valid & in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      mem_cnt  <= '0;
      inflight <= '0;
      head_vld <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      mem_cnt  <= mem_cnt + CNT_W'(wr_en) - CNT_W'(rd_en);
      inflight <= inflight + CNT_W'(accept) - CNT_W'(wr_en);
      if (rd_en) begin
        head_vld <= 1'b1;
      end else if (pop) begin
        head_vld <= 1'b0;
      end
    end
  end

  // storage and head payload
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr].data <= wr_data;
      mem[wr_ptr].tag  <= wr_side_i.tag;
    end
    if (rd_en) begin
      head_beat <= mem[rd_ptr];
    end
  end

  assign out_valid = head_vld;
  assign out_beat  = head_beat;

  // **************************************************
  // checks
  // **************************************************
  a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> mem_cnt < CNT_W'(`IQCOR_QDEPTH));
  // a read needs the pointers to show a stored entry, equal pointers only when full
  a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> (wr_ptr != rd_ptr || mem_cnt == CNT_W'(`IQCOR_QDEPTH)));
  a_lane_sync: assert property (@(posedge clk) disable iff (!rst_n)
    wr_side_i.vld == wr_side_q.vld && (!wr_side_i.vld || wr_side_i.tag == wr_side_q.tag));
  a_inflight_max: assert property (@(posedge clk) disable iff (!rst_n)
    inflight <= CNT_W'(`IQCOR_MUL_LAT + 1));

endmodule

// ==== iqcor_top.sv ====
/*
 * iq imbalance corrector top
 * i lane, q lane and the credit-based output queue
 */

`timescale 1ns/100ps

module iqcor_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  iqcor_pkg::coef_set_t coef,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  iqcor_pkg::iq_beat_t  in_beat,
  output logic                 out_valid,
  input  logic                 out_ready,
  output iqcor_pkg::iq_beat_t  out_beat
);

  // accept strobe from the queue, with the tag, enters both lanes
  logic                accept;
  iqcor_pkg::side_t    acc_side;

  iqcor_pkg::sample_t  y_i;
  iqcor_pkg::sample_t  y_q;
  iqcor_pkg::side_t    side_i;
  iqcor_pkg::side_t    side_q;
  iqcor_pkg::iq_pair_t lane_data;

  assign acc_side.vld = accept;
  assign acc_side.tag = in_beat.tag;
  assign lane_data.i  = y_i;
  assign lane_data.q  = y_q;

  // out_i = i*c_ii + q*c_iq
  iqcor_lane lane_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .x_i      (in_beat.data.i),
    .x_q      (in_beat.data.q),
    .c_a      (coef.c_ii),
    .c_b      (coef.c_iq),
    .side_in  (acc_side),
    .y        (y_i),
    .side_out (side_i)
  );

  // out_q = i*c_qi + q*c_qq
  iqcor_lane lane_q (
    .clk      (clk),
    .rst_n    (rst_n),
    .x_i      (in_beat.data.i),
    .x_q      (in_beat.data.q),
    .c_a      (coef.c_qi),
    .c_b      (coef.c_qq),
    .side_in  (acc_side),
    .y        (y_q),
    .side_out (side_q)
  );

  iqcor_outq outq (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .accept    (accept),
    .wr_side_i (side_i),
    .wr_side_q (side_q),
    .wr_data   (lane_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

endmodule

// ==== tb_iqcor.sv ====
/*
 * testbench for the iq imbalance corrector
 * reads coefficient and sample cases, paces input and output with an lfsr,
 * checks every output beat in order plus the single-sample latency
 */

`timescale 1ns/100ps

module tb_iqcor;

  // one line of the case file
  typedef struct packed {
    logic                 is_coef;
    iqcor_pkg::coef_set_t coef;
    iqcor_pkg::iq_beat_t  beat;
    iqcor_pkg::iq_pair_t  exp_pair;
  } case_t;

  logic                 clk = 1'b0;
  logic                 rst_n;
  iqcor_pkg::coef_set_t coef;
  logic                 in_valid;
  logic                 in_ready;
  iqcor_pkg::iq_beat_t  in_beat;
  logic                 out_valid;
  logic                 out_ready;
  iqcor_pkg::iq_beat_t  out_beat;

  case_t               cases [$];
  // beats accepted by the DUT and not yet seen at the output
  iqcor_pkg::iq_beat_t exp_q [$];
  int                  n_samples = 0;
  int                  rx_cnt = 0;
  int                  cycle_cnt = 0;
  int                  cycle_limit = 0;
  logic [31:0]         lfsr = 32'h35a1;

  iqcor_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef      (coef),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // **************************************************
  // helpers
  // **************************************************
  task automatic abort_run(input string why);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", why);
  endtask

  // galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic read_cases();
    int          fd;
    int          ch;
    int          n;
    bit          done;
    logic [7:0]  t;
    logic [15:0] f0;
    logic [15:0] f1;
    logic [15:0] f2;
    logic [15:0] f3;
    case_t       c;
    fd   = $fopen("iqcor_cases.txt", "r");
    done = 1'b0;
    if (fd == 0) begin
      abort_run("cannot open iqcor_cases.txt");
    end else begin
      while (!done) begin
        ch = $fgetc(fd);
        c  = '0;
        if (ch < 0) begin
          done = 1'b1;
        end else if (ch == "#") begin
          // comment runs to end of line
          while (ch >= 0 && ch != "\n") begin
            ch = $fgetc(fd);
          end
        end else if (ch == "C") begin
          n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          assert (n == 4) else abort_run("short coefficient line in iqcor_cases.txt");
          c.is_coef   = 1'b1;
          c.coef.c_ii = f0;
          c.coef.c_iq = f1;
          c.coef.c_qi = f2;
          c.coef.c_qq = f3;
          cases.push_back(c);
        end else if (ch == "S") begin
          n = $fscanf(fd, "%h %h %h %h %h", t, f0, f1, f2, f3);
          assert (n == 5) else abort_run("short sample line in iqcor_cases.txt");
          c.beat.tag    = t;
          c.beat.data.i = f0;
          c.beat.data.q = f1;
          c.exp_pair.i  = f2;
          c.exp_pair.q  = f3;
          cases.push_back(c);
          n_samples++;
        end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
          abort_run("unknown line type in iqcor_cases.txt");
        end
      end
      $fclose(fd);
    end
  endtask

  // compare one output beat with the oldest accepted one
  task automatic check_beat(input iqcor_pkg::iq_beat_t got);
    iqcor_pkg::iq_beat_t want;
    assert (exp_q.size() != 0) else abort_run("output beat with no sample pending");
    want = exp_q.pop_front();
    assert (got.tag == want.tag) else begin
      $display("ERROR out_beat.tag expected %h got %h", want.tag, got.tag);
      abort_run("tag mismatch");
    end
    assert (got.data.i == want.data.i) else begin
      $display("ERROR out_beat.data.i expected %h got %h (tag %h)", want.data.i,
               got.data.i, want.tag);
      abort_run("out_i mismatch");
    end
    assert (got.data.q == want.data.q) else begin
      $display("ERROR out_beat.data.q expected %h got %h (tag %h)", want.data.q,
               got.data.q, want.tag);
      abort_run("out_q mismatch");
    end
    rx_cnt++;
  endtask

  // **************************************************
  // cycle count and timeout
  // **************************************************
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0) begin
      assert (cycle_cnt < cycle_limit) else begin
        abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
      end
    end
  end

  // **************************************************
  // stimulus and checking, all on the falling edge
  // **************************************************
  initial begin : stimulus
    case_t               cur;
    case_t               sent;
    iqcor_pkg::iq_beat_t held_beat;
    iqcor_pkg::iq_beat_t want;
    bit                  rdy_seen;
    bit                  held;
    bit                  lat_mode;
    bit                  lat_sent;
    bit                  gate;
    int                  acc_cycle;
    int                  idx;
    rst_n     = 1'b0;
    coef      = '0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    rdy_seen  = 1'b0;
    held      = 1'b0;
    held_beat = '0;
    // the first sample runs alone with out_ready high to measure latency
    lat_mode  = 1'b1;
    lat_sent  = 1'b0;
    acc_cycle = 0;
    idx       = 0;
    sent      = '0;
    read_cases();
    cycle_limit = 40 * n_samples + 200;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (in_ready == 1'b1) else begin
      $display("ERROR in_ready expected %h got %h", 1'b1, in_ready);
      abort_run("in_ready low after reset");
    end
    assert (out_valid == 1'b0) else begin
      $display("ERROR out_valid expected %h got %h", 1'b0, out_valid);
      abort_run("out_valid high after reset");
    end

    while (idx < cases.size() || in_valid || exp_q.size() != 0) begin
      @(negedge clk);
      // a stalled beat must hold still
      if (held) begin
        assert (out_valid == 1'b1) else abort_run("out_valid dropped before its beat was taken");
        assert (out_beat == held_beat) else begin
          $display("ERROR out_beat expected %h got %h", held_beat, out_beat);
          abort_run("out_beat changed while stalled");
        end
      end
      if (lat_mode) begin
        out_ready = 1'b1;
      end else begin
        lfsr      = lfsr_step(lfsr);
        out_ready = lfsr[0];
      end
      if (out_valid && out_ready) begin
        check_beat(out_beat);
        if (lat_mode) begin
          assert (cycle_cnt - acc_cycle == 5) else begin
            $display("ERROR out_valid latency expected %h got %h", 5, cycle_cnt - acc_cycle);
            abort_run("wrong single-sample latency");
          end
          lat_mode = 1'b0;
        end
      end
      held      = out_valid && !out_ready;
      held_beat = out_beat;

      // input side, beat seen with in_ready high last time has been taken
      if (in_valid && rdy_seen) begin
        in_valid = 1'b0;
      end
      if (!in_valid && idx < cases.size() && !(lat_mode && lat_sent)) begin
        cur = cases[idx];
        if (cur.is_coef) begin
          // coefficients change only with the DUT drained
          if (exp_q.size() == 0) begin
            coef = cur.coef;
            idx++;
          end
        end else begin
          if (lat_mode) begin
            gate = 1'b1;
          end else begin
            lfsr = lfsr_step(lfsr);
            gate = lfsr[0];
          end
          if (gate) begin
            in_beat  = cur.beat;
            in_valid = 1'b1;
            sent     = cur;
            lat_sent = lat_mode;
            idx++;
          end
        end
      end
      rdy_seen = in_ready;
      if (in_valid && rdy_seen) begin
        want.data = sent.exp_pair;
        want.tag  = sent.beat.tag;
        exp_q.push_back(want);
        if (lat_mode) begin
          acc_cycle = cycle_cnt + 1;
        end
      end
    end

    // let the last transfer finish, then no further beat may show up
    @(negedge clk);
    out_ready = 1'b0;
    repeat (2) @(negedge clk);
    if (rx_cnt == n_samples && !out_valid) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run($sformatf("received %0d beats for %0d samples, out_valid %0b at the end",
                          rx_cnt, n_samples, out_valid));
    end
  end

endmodule

// ==== iqcor_cases.txt ====
# C c_ii c_iq c_qi c_qq            : coefficient load, signed q2.14 in hex
# S tag i q expected_i expected_q  : sample pair and corrected result in hex
# identity
C 4000 0000 0000 4000
S 01 1234 5678 1234 5678
S 02 8000 7fff 8000 7fff
S 03 ffff 0001 ffff 0001
S 04 0000 0000 0000 0000
S 05 a5a5 5a5a a5a5 5a5a
S 06 7fff 8000 7fff 8000
# cross terms 0.5 0.25 -0.25 1.5, floor rounding
C 2000 1000 f000 6000
S 10 0064 0028 003c 0023
S 11 0003 0001 0001 0000
S 12 fffd ffff fffe ffff
S 13 fc18 01f4 fe89 03e8
S 14 0001 ffff 0000 fffe
S 15 0005 fffe 0002 fffb
S 16 1000 2000 1000 2c00
# near +2 and -2, saturation
C 7fff 7fff 8000 8000
S 20 7fff 7fff 7fff 8000
S 21 8000 8000 8000 7fff
S 22 0001 0001 0003 fffc
S 23 ffff 0000 fffe 0002
S 24 4000 c000 0000 0000
S 25 2000 2000 7fff 8000
S 26 2000 2001 7fff 8000
# swap i and q, traffic under back-pressure
C 0000 4000 4000 0000
S 30 0102 0304 0304 0102
S 31 1111 2222 2222 1111
S 32 8001 7ffe 7ffe 8001
S 33 fedc ba98 ba98 fedc
S 34 0f0f f0f0 f0f0 0f0f
S 35 1357 9bdf 9bdf 1357
S 36 2468 ace0 ace0 2468
S 37 7fff 0000 0000 7fff
S 38 0000 8000 8000 0000
S 39 dead beef beef dead
S 3a cafe 1234 1234 cafe
S 3b 4321 8765 8765 4321

// ==== iqcor.f ====
+incdir+.
iqcor_pkg.sv
iqcor_mul.sv
iqcor_lane.sv
iqcor_outq.sv
iqcor_top.sv
tb_iqcor.sv

// ==== Makefile ====
# Verilator build and run of the IQ imbalance corrector testbench

TOP := tb_iqcor

.PHONY: all build run clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): iqcor.f iqcor_consts.svh iqcor_pkg.sv iqcor_mul.sv iqcor_lane.sv \
		iqcor_outq.sv iqcor_top.sv tb_iqcor.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f iqcor.f

# exit status of the simulation is the pass or fail result
run: build
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
